// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := cabinet_io_tb
FILELIST  := cabinet_io.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: cabinet_io.f
hw/astro_pkg.sv
hw/cabinet_config.sv
hw/switch_matrix.sv
hw/audio_mixer.sv
hw/cabinet_io.sv
verification/cabinet_io_tb.sv

// File: hw/astro_pkg.sv
package astro_pkg;

	// ============================================================
	// Game select codes, as written by the download port
	// ============================================================
	localparam logic [7:0] game_space_zap  = 8'd3;
	localparam logic [7:0] game_gorf       = 8'd4;
	localparam logic [7:0] game_wow        = 8'd5;
	localparam logic [7:0] game_robby      = 8'd6;
	// Program 1 board runs the Gorf cabinet layout
	localparam logic [7:0] game_gorf_prog1 = 8'd7;

	// Download index that qualifies each write
	localparam logic [7:0] index_game = 8'd1;
	localparam logic [7:0] index_dip  = 8'd254;

	// Number of DIP switch bytes held
	localparam int dip_count = 8;

	// ============================================================
	// Switch matrix column strobes and idle row
	// ============================================================
	localparam logic [7:0] col_ctrl0 = 8'h01;
	localparam logic [7:0] col_ctrl1 = 8'h02;
	localparam logic [7:0] col_ctrl2 = 8'h04;
	localparam logic [7:0] col_dip3  = 8'h08;
	// Rows are active low, nothing pressed reads all ones
	localparam logic [7:0] row_idle  = 8'hff;

	// Bit positions inside a joystick word
	localparam int btn_right = 0;
	localparam int btn_left  = 1;
	localparam int btn_down  = 2;
	localparam int btn_up    = 3;
	localparam int btn_fire  = 4;
	localparam int btn_fire2 = 5;
	// Start 2 sits just above start 1
	localparam int btn_start = 6;
	localparam int btn_coin  = 8;

	// Silence level of halved 16 bit samples
	localparam int silence_offset = 16384;

endpackage

// File: hw/audio_mixer.sv
module audio_mixer #(
	parameter int sample_width = 16
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic [sample_width-1:0] chip_l,
	input  logic [sample_width-1:0] chip_r,
	input  logic [sample_width-1:0] sample_l,
	input  logic [sample_width-1:0] sample_r,
	input  logic                    speech_select,
	input  logic                    stereo,
	input  logic                    plus_samples,
	input  logic                    gorf_cabinet,
	output logic [sample_width-1:0] audio_l,
	output logic [sample_width-1:0] audio_r
);

	// ============================================================
	// Silence offset scaled to the sample width
	// ============================================================
	// 16384 is 2^14 at 16 bits, so rescale to 2^(sample_width-2)
	localparam logic [sample_width+15:0] offset_scaled =
		(sample_width + 16)'(astro_pkg::silence_offset) << (sample_width - 2);
	localparam logic [sample_width:0] cab_offset = offset_scaled[sample_width+14:14];

	logic [sample_width-1:0] half_chip_l, half_chip_r;
	logic [sample_width-1:0] half_sample_l, half_sample_r;
	logic [sample_width-1:0] mix_l, mix_r;
	logic [sample_width:0]   cab_sum;
	logic [sample_width-1:0] cab_l;
	logic [sample_width-1:0] next_l, next_r;

	// Drop the LSB, halves can be summed without a carry out
	assign half_chip_l   = chip_l >> 1;
	assign half_chip_r   = chip_r >> 1;
	assign half_sample_l = sample_l >> 1;
	assign half_sample_r = sample_r >> 1;

	assign mix_l = half_chip_l + half_sample_l;
	assign mix_r = half_chip_r + half_sample_r;

	// Lower cabinet speaker, chip audio lifted to the sample silence level
	assign cab_sum = {1'b0, chip_l} + cab_offset;
	// Clip at full scale
	assign cab_l = cab_sum[sample_width] ? '1 : cab_sum[sample_width-1:0];

	// ============================================================
	// Per game channel routing
	// ============================================================
	always_comb begin
		// Upper speaker plays the right sound chip only
		if (gorf_cabinet) next_r = chip_r;
		else if (plus_samples) next_r = mix_r;
		else if (stereo) next_r = chip_r;
		else next_r = chip_l;

		if (gorf_cabinet) begin
			// CPU port switches the lower speaker between speech and chip
			if (speech_select) next_l = half_sample_l;
			else next_l = cab_l;
		end else if (plus_samples) begin
			next_l = mix_l;
		end else begin
			next_l = chip_l;
		end
	end

	// Output registers, one cycle from inputs
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= next_l;
			audio_r <= next_r;
		end
	end

endmodule

// File: hw/cabinet_config.sv
module cabinet_config (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic        is_space_zap,
	output logic        is_gorf,
	output logic        is_wow,
	output logic        is_robby,
	output logic        stereo,
	output logic        plus_samples,
	output logic        gorf_cabinet,
	output logic [7:0]  dip0,
	output logic [7:0]  dip2,
	output logic [7:0]  dip3
);

	// Address bits needed to pick one DIP byte
	localparam int dip_addr_width = $clog2(astro_pkg::dip_count);

	logic [7:0] game;
	logic [7:0] dip [astro_pkg::dip_count];

	logic game_write;
	logic dip_write;

	// ============================================================
	// Download decode
	// ============================================================
	assign game_write = ioctl_wr && (ioctl_index == astro_pkg::index_game);
	// Addresses past the last DIP byte are dropped
	assign dip_write  = ioctl_wr && (ioctl_index == astro_pkg::index_dip)
		&& (ioctl_addr < 25'(astro_pkg::dip_count));

	// Game byte, zero after reset means unknown game
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game <= 8'd0;
		end else if (game_write) begin
			game <= ioctl_dout;
		end
	end

	// DIP bytes, all switches off after reset
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < astro_pkg::dip_count; i++) begin
				dip[i] <= 8'd0;
			end
		end else if (dip_write) begin
			dip[ioctl_addr[dip_addr_width-1:0]] <= ioctl_dout;
		end
	end

	// ============================================================
	// Game flags, one cycle behind the game byte
	// ============================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			is_space_zap <= 1'b0;
			is_gorf      <= 1'b0;
			is_wow       <= 1'b0;
			is_robby     <= 1'b0;
		end else begin
			is_space_zap <= (game == astro_pkg::game_space_zap);
			// Program 1 shares the Gorf cabinet
			is_gorf      <= (game == astro_pkg::game_gorf)
				|| (game == astro_pkg::game_gorf_prog1);
			is_wow       <= (game == astro_pkg::game_wow);
			is_robby     <= (game == astro_pkg::game_robby);
		end
	end

	// Two sound chips fitted
	assign stereo       = is_gorf | is_wow | is_robby;
	// Sound chip audio mixed with speech samples
	assign plus_samples = is_gorf | is_wow;
	// Split speakers of the Gorf cabinet, chosen by DIP 0 bit 0
	assign gorf_cabinet = is_gorf & dip[0][0];

	assign dip0 = dip[0];
	assign dip2 = dip[2];
	assign dip3 = dip[3];

endmodule

// File: hw/cabinet_io.sv
module cabinet_io #(
	parameter int sample_width = 16
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	// Download port
	input  logic                    ioctl_wr,
	input  logic [7:0]              ioctl_index,
	input  logic [24:0]             ioctl_addr,
	input  logic [7:0]              ioctl_dout,
	// Switch matrix
	input  logic [7:0]              col_select,
	input  logic [15:0]             joystick_0,
	input  logic [15:0]             joystick_1,
	input  logic                    speech_busy,
	output logic [7:0]              row_data,
	// Audio
	input  logic [sample_width-1:0] chip_l,
	input  logic [sample_width-1:0] chip_r,
	input  logic [sample_width-1:0] sample_l,
	input  logic [sample_width-1:0] sample_r,
	input  logic                    speech_select,
	output logic [sample_width-1:0] audio_l,
	output logic [sample_width-1:0] audio_r
);

	// ============================================================
	// Configuration to matrix and mixer
	// ============================================================
	logic is_space_zap, is_gorf, is_wow, is_robby;
	logic stereo, plus_samples, gorf_cabinet;
	logic [7:0] dip0, dip2, dip3;

	// Game byte and DIP capture
	cabinet_config u_config (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.ioctl_wr     (ioctl_wr),
		.ioctl_index  (ioctl_index),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.is_space_zap (is_space_zap),
		.is_gorf      (is_gorf),
		.is_wow       (is_wow),
		.is_robby     (is_robby),
		.stereo       (stereo),
		.plus_samples (plus_samples),
		.gorf_cabinet (gorf_cabinet),
		.dip0         (dip0),
		.dip2         (dip2),
		.dip3         (dip3)
	);

	// Control panel rows, combinational from the column strobe
	switch_matrix u_matrix (
		.col_select   (col_select),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1),
		.speech_busy  (speech_busy),
		.is_space_zap (is_space_zap),
		.is_gorf      (is_gorf),
		.is_wow       (is_wow),
		.is_robby     (is_robby),
		.dip0         (dip0),
		.dip2         (dip2),
		.dip3         (dip3),
		.row_data     (row_data)
	);

	// Speaker mix
	audio_mixer #(
		.sample_width (sample_width)
	) u_mixer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.chip_l        (chip_l),
		.chip_r        (chip_r),
		.sample_l      (sample_l),
		.sample_r      (sample_r),
		.speech_select (speech_select),
		.stereo        (stereo),
		.plus_samples  (plus_samples),
		.gorf_cabinet  (gorf_cabinet),
		.audio_l       (audio_l),
		.audio_r       (audio_r)
	);

endmodule

// File: hw/switch_matrix.sv
module switch_matrix (
	input  logic [7:0]  col_select,
	input  logic [15:0] joystick_0,
	input  logic [15:0] joystick_1,
	input  logic        speech_busy,
	input  logic        is_space_zap,
	input  logic        is_gorf,
	input  logic        is_wow,
	input  logic        is_robby,
	input  logic [7:0]  dip0,
	input  logic [7:0]  dip2,
	input  logic [7:0]  dip3,
	output logic [7:0]  row_data
);

	// ============================================================
	// Active high player buttons from the joystick words
	// ============================================================
	logic p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire2;
	logic p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire2;
	logic start1, start2, coin;

	assign p1_up    = joystick_0[astro_pkg::btn_up];
	assign p1_down  = joystick_0[astro_pkg::btn_down];
	assign p1_left  = joystick_0[astro_pkg::btn_left];
	assign p1_right = joystick_0[astro_pkg::btn_right];
	assign p1_fire  = joystick_0[astro_pkg::btn_fire];
	assign p1_fire2 = joystick_0[astro_pkg::btn_fire2];

	assign p2_up    = joystick_1[astro_pkg::btn_up];
	assign p2_down  = joystick_1[astro_pkg::btn_down];
	assign p2_left  = joystick_1[astro_pkg::btn_left];
	assign p2_right = joystick_1[astro_pkg::btn_right];
	assign p2_fire  = joystick_1[astro_pkg::btn_fire];
	assign p2_fire2 = joystick_1[astro_pkg::btn_fire2];

	// Starts and coin all come from the first controller
	assign start1 = joystick_0[astro_pkg::btn_start];
	assign start2 = joystick_0[astro_pkg::btn_start + 1];
	assign coin   = joystick_0[astro_pkg::btn_coin];

	// ============================================================
	// Active low row bytes per game with the MSB first
	// ============================================================
	logic [7:0] sz_col1, sz_col2, sz_col4;
	logic [7:0] gf_col1, gf_col2, gf_col4;
	logic [7:0] ww_col1, ww_col2, ww_col4;
	logic [7:0] rr_col1, rr_col2, rr_col4;

	// Space Zap
	assign sz_col1 = {2'b11, ~start2, ~start1, dip2[1], 1'b1, ~coin, 1'b1};
	assign sz_col2 = {3'b111, ~p2_fire, ~p2_right, ~p2_left, ~p2_down, ~p2_up};
	assign sz_col4 = {2'b11, dip2[0], ~p1_fire, ~p1_right, ~p1_left, ~p1_down, ~p1_up};

	// Gorf reports speech status in the top bit of the player 1 row
	assign gf_col1 = {dip2[2], dip2[0], ~start2, ~start1, 1'b1, dip2[1], ~coin, 1'b1};
	assign gf_col2 = {3'b001, ~p2_fire, ~p2_right, ~p2_left, ~p2_down, ~p2_up};
	assign gf_col4 = {speech_busy, 2'b01, ~p1_fire, ~p1_right, ~p1_left, ~p1_down, ~p1_up};

	// Wizard of Wor reads the digital Fire2b move button active high
	assign ww_col1 = {dip2[2], ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
	assign ww_col2 = {2'b11, ~p2_fire, p2_fire2, ~p2_right, ~p2_left, ~p2_down, ~p2_up};
	assign ww_col4 = {speech_busy, 1'b1, ~p1_fire, p1_fire2,
		~p1_right, ~p1_left, ~p1_down, ~p1_up};

	// Robby Roto
	assign rr_col1 = {1'b0, ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
	assign rr_col2 = {2'b11, ~p2_fire, 1'b1, ~p2_right, ~p2_left, ~p2_down, ~p2_up};
	assign rr_col4 = {2'b11, ~p1_fire, 1'b1, ~p1_right, ~p1_left, ~p1_down, ~p1_up};

	// ============================================================
	// Column select answered in the same cycle
	// ============================================================
	always_comb begin
		row_data = astro_pkg::row_idle;
		case (col_select)
			astro_pkg::col_ctrl0: begin
				if (is_space_zap) row_data = sz_col1;
				else if (is_gorf) row_data = gf_col1;
				else if (is_wow) row_data = ww_col1;
				else if (is_robby) row_data = rr_col1;
			end
			astro_pkg::col_ctrl1: begin
				if (is_space_zap) row_data = sz_col2;
				else if (is_gorf) row_data = gf_col2;
				else if (is_wow) row_data = ww_col2;
				else if (is_robby) row_data = rr_col2;
			end
			astro_pkg::col_ctrl2: begin
				if (is_space_zap) row_data = sz_col4;
				else if (is_gorf) row_data = gf_col4;
				else if (is_wow) row_data = ww_col4;
				else if (is_robby) row_data = rr_col4;
			end
			// DIP bank 3 is wired straight to this column on every board
			astro_pkg::col_dip3: row_data = dip3;
			default: row_data = astro_pkg::row_idle;
		endcase
	end

endmodule

// File: verification/cabinet_io_tb.sv
module cabinet_io_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int sample_width = 16;
	localparam int test_count = 6;
	localparam int cycles_per_test = 400;
	localparam int clk_period = 4;
	// Lower speaker offset of 2^(w-2) in full scale terms
	localparam longint cab_offset =
		(longint'(astro_pkg::silence_offset) << (sample_width - 2)) >> 14;
	localparam longint full_scale = (64'sd1 <<< sample_width) - 1;

	logic clk_sys, reset, ioctl_wr, speech_busy, speech_select;
	logic [7:0] ioctl_index, ioctl_dout, col_select, row_data;
	logic [24:0] ioctl_addr;
	logic [15:0] joystick_0, joystick_1;
	logic [sample_width-1:0] chip_l, chip_r, sample_l, sample_r, audio_l, audio_r;

	// Reference state that follows the download writes at once
	logic [7:0] model_game;
	logic [7:0] model_dip [astro_pkg::dip_count];
	logic row_check, audio_check, audio_check_d, reset_check;
	logic [7:0] exp_row;
	logic [sample_width-1:0] exp_l, exp_r, exp_l_d, exp_r_d;
	string test_name;
	int row_errors = 0;
	int audio_errors = 0;

	cabinet_io #(.sample_width(sample_width)) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// ============================================================
	// Reference model of the row bytes and speaker mix
	// ============================================================
	function automatic logic [7:0] model_row(input logic [7:0] game, input logic [7:0] col,
		input logic [15:0] j0, input logic [15:0] j1, input logic busy,
		input logic [7:0] d2, input logic [7:0] d3);
		logic [4:0] n1, n2;
		logic ns1, ns2, nc, known;
		logic [7:0] c1, c2, c4;
		// Inverted fire, right, left, down, up
		n1 = ~{j0[astro_pkg::btn_fire], j0[astro_pkg::btn_right], j0[astro_pkg::btn_left],
			j0[astro_pkg::btn_down], j0[astro_pkg::btn_up]};
		n2 = ~{j1[astro_pkg::btn_fire], j1[astro_pkg::btn_right], j1[astro_pkg::btn_left],
			j1[astro_pkg::btn_down], j1[astro_pkg::btn_up]};
		ns1 = ~j0[astro_pkg::btn_start];
		ns2 = ~j0[astro_pkg::btn_start + 1];
		nc = ~j0[astro_pkg::btn_coin];
		known = 1'b1;
		c1 = astro_pkg::row_idle;
		c2 = astro_pkg::row_idle;
		c4 = astro_pkg::row_idle;
		case (game)
			astro_pkg::game_space_zap: begin
				c1 = {2'b11, ns2, ns1, d2[1], 1'b1, nc, 1'b1};
				c2 = {3'b111, n2};
				c4 = {2'b11, d2[0], n1};
			end
			astro_pkg::game_gorf, astro_pkg::game_gorf_prog1: begin
				c1 = {d2[2], d2[0], ns2, ns1, 1'b1, d2[1], nc, 1'b1};
				c2 = {3'b001, n2};
				c4 = {busy, 2'b01, n1};
			end
			astro_pkg::game_wow: begin
				c1 = {d2[2], ns2, ns1, 1'b1, d2[1], 1'b1, nc, 1'b1};
				c2 = {2'b11, n2[4], j1[astro_pkg::btn_fire2], n2[3:0]};
				c4 = {busy, 1'b1, n1[4], j0[astro_pkg::btn_fire2], n1[3:0]};
			end
			astro_pkg::game_robby: begin
				c1 = {1'b0, ns2, ns1, 1'b1, d2[1], 1'b1, nc, 1'b1};
				c2 = {2'b11, n2[4], 1'b1, n2[3:0]};
				c4 = {2'b11, n1[4], 1'b1, n1[3:0]};
			end
			default: known = 1'b0;
		endcase
		// DIP bank 3 answers whatever the game
		if (col == astro_pkg::col_dip3) return d3;
		if (!known) return astro_pkg::row_idle;
		if (col == astro_pkg::col_ctrl0) return c1;
		if (col == astro_pkg::col_ctrl1) return c2;
		if (col == astro_pkg::col_ctrl2) return c4;
		return astro_pkg::row_idle;
	endfunction

	function automatic logic [sample_width-1:0] model_left(input logic [7:0] game,
		input logic cab_dip, input logic speech,
		input logic [sample_width-1:0] cl, input logic [sample_width-1:0] sl);
		logic gorf;
		longint sum;
		gorf = (game == astro_pkg::game_gorf) || (game == astro_pkg::game_gorf_prog1);
		if (gorf && cab_dip) begin
			if (speech) return sl >> 1;
			sum = longint'(cl) + cab_offset;
			// Saturate at full scale
			if (sum > full_scale) return '1;
			return sample_width'(sum);
		end
		if (gorf || game == astro_pkg::game_wow) return (cl >> 1) + (sl >> 1);
		return cl;
	endfunction

	function automatic logic [sample_width-1:0] model_right(input logic [7:0] game,
		input logic cab_dip, input logic [sample_width-1:0] cl,
		input logic [sample_width-1:0] cr, input logic [sample_width-1:0] sr);
		logic gorf, wow;
		gorf = (game == astro_pkg::game_gorf) || (game == astro_pkg::game_gorf_prog1);
		wow = (game == astro_pkg::game_wow);
		if (gorf && cab_dip) return cr;
		if (gorf || wow) return (cr >> 1) + (sr >> 1);
		if (game == astro_pkg::game_robby) return cr;
		// Mono board plays the left chip on both speakers
		return cl;
	endfunction

	always_comb begin
		exp_row = model_row(model_game, col_select, joystick_0, joystick_1, speech_busy,
			model_dip[2], model_dip[3]);
		exp_l = model_left(model_game, model_dip[0][0], speech_select, chip_l, sample_l);
		exp_r = model_right(model_game, model_dip[0][0], chip_l, chip_r, sample_r);
	end

	// Expectation delayed to match the one audio register
	always @(posedge clk_sys) begin
		audio_check_d <= audio_check;
		exp_l_d <= exp_l;
		exp_r_d <= exp_r;
	end

	// ============================================================
	// Checks sampled mid cycle where everything is settled
	// ============================================================
	row_matches: assert property (@(negedge clk_sys) disable iff (reset)
		row_check |-> row_data == exp_row)
	else begin
		row_errors++;
		$display("Mismatch %s col %h: expected %h, actual %h",
			test_name, col_select, exp_row, row_data);
	end

	left_matches: assert property (@(negedge clk_sys) disable iff (reset)
		audio_check_d |-> audio_l == exp_l_d)
	else begin
		audio_errors++;
		$display("Mismatch %s audio_l: expected %h, actual %h", test_name, exp_l_d, audio_l);
	end

	right_matches: assert property (@(negedge clk_sys) disable iff (reset)
		audio_check_d |-> audio_r == exp_r_d)
	else begin
		audio_errors++;
		$display("Mismatch %s audio_r: expected %h, actual %h", test_name, exp_r_d, audio_r);
	end

	quiet_after_reset: assert property (@(negedge clk_sys) disable iff (reset)
		reset_check |-> (audio_l == '0) && (audio_r == '0))
	else begin
		audio_errors++;
		$display("Mismatch %s audio: expected 0/0, actual %h/%h", test_name, audio_l, audio_r);
	end

	// One strobe on the download port
	task automatic write_download(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		row_check <= 1'b0;
		audio_check <= 1'b0;
		ioctl_wr <= 1'b1;
		ioctl_index <= index;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		if (index == astro_pkg::index_game) begin
			model_game = data;
		end else if (index == astro_pkg::index_dip && addr < 25'(astro_pkg::dip_count)) begin
			model_dip[addr[2:0]] = data;
		end
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// Random buttons while the column walks the strobes or takes any value
	task automatic check_rows(input int cycles, input bit any_col);
		logic [7:0] strobes [4];
		strobes = '{astro_pkg::col_ctrl0, astro_pkg::col_ctrl1,
			astro_pkg::col_ctrl2, astro_pkg::col_dip3};
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_sys);
			joystick_0 <= 16'($urandom);
			joystick_1 <= 16'($urandom);
			speech_busy <= 1'($urandom);
			col_select <= any_col ? 8'($urandom) : strobes[i % 4];
			row_check <= 1'b1;
		end
		@(posedge clk_sys);
		row_check <= 1'b0;
	endtask

	// Random samples with chip_l held near full scale when loud
	task automatic check_audio(input int cycles, input bit loud);
		for (int i = 0; i < cycles; i++) begin
			@(posedge clk_sys);
			chip_l <= loud ? ~sample_width'($urandom_range(0, 20000)) : sample_width'($urandom);
			chip_r <= sample_width'($urandom);
			sample_l <= sample_width'($urandom);
			sample_r <= sample_width'($urandom);
			speech_select <= 1'($urandom);
			audio_check <= 1'b1;
		end
		@(posedge clk_sys);
		audio_check <= 1'b0;
	endtask

	initial begin
		#((test_count * cycles_per_test + 100) * clk_period);
		$display("Timeout: tests did not finish within %0d cycles",
			test_count * cycles_per_test + 100);
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		void'($urandom(32'h40ae));
		reset <= 1'b1;
		ioctl_wr <= 1'b0;
		ioctl_index <= 8'd0;
		ioctl_addr <= 25'd0;
		ioctl_dout <= 8'd0;
		col_select <= 8'd0;
		joystick_0 <= 16'd0;
		joystick_1 <= 16'd0;
		speech_busy <= 1'b0;
		chip_l <= '0;
		chip_r <= '0;
		sample_l <= '0;
		sample_r <= '0;
		speech_select <= 1'b0;
		row_check <= 1'b0;
		audio_check <= 1'b0;
		reset_check <= 1'b0;
		model_game = 8'd0;
		for (int i = 0; i < astro_pkg::dip_count; i++) model_dip[i] = 8'd0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		// Audio still holds its reset value until the next edge
		reset_check <= 1'b1;

		test_name = "reset_state";
		@(posedge clk_sys);
		check_rows(8, 1'b0);
		reset_check <= 1'b0;

		test_name = "game_select";
		for (int g = 2; g <= 7; g++) begin
			write_download(astro_pkg::index_game, 25'd0, 8'(g));
			check_rows(40, 1'b0);
		end

		test_name = "dip_capture";
		write_download(astro_pkg::index_game, 25'd0, astro_pkg::game_gorf);
		for (int i = 0; i < 16; i++) begin
			write_download(astro_pkg::index_dip, 25'($urandom_range(0, 7)), 8'($urandom));
			check_rows(8, 1'b0);
		end
		// Wrong index and out of range address are both ignored
		// Both aim new data at DIP byte 3 so a wrong capture shows in column 8
		write_download(8'd253, 25'd3, ~model_dip[3]);
		write_download(astro_pkg::index_dip, 25'(8 * $urandom_range(1, 24) + 3),
			~model_dip[3]);
		check_rows(16, 1'b0);

		test_name = "unused_column";
		check_rows(200, 1'b1);

		test_name = "audio_modes";
		write_download(astro_pkg::index_dip, 25'd0, 8'h00);
		for (int g = 2; g <= 7; g++) begin
			write_download(astro_pkg::index_game, 25'd0, 8'(g));
			check_audio(40, 1'b0);
		end

		test_name = "gorf_cabinet";
		write_download(astro_pkg::index_dip, 25'd0, 8'h01);
		write_download(astro_pkg::index_game, 25'd0, astro_pkg::game_gorf);
		check_audio(100, 1'b0);
		check_audio(100, 1'b1);

		repeat (2) @(posedge clk_sys);
		$display("Errors: %0d row, %0d audio, %0d total",
			row_errors, audio_errors, row_errors + audio_errors);
		if (row_errors + audio_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
